/* verif/fetch_input.txt */
# E <fetch_en hex> | R <thread> <pc hex> | W <cycles> | C <thread> <min hits>
# Hit counts in C lines are cumulative per thread since reset
W 4
E 0
W 3
E 1
W 120
C 0 10
E f
W 200
C 1 8
C 2 8
C 3 8
R 2 00004000
W 100
C 2 12
E 5
W 150
R 0 00008100
W 150
C 0 30
E a
W 150
C 3 20
E f
R 3 00002000
R 1 0000c040
W 200
C 1 25
C 3 30

/* flist.f */
rtl/fetch_pkg.sv
rtl/fetch_event_decoder.sv
rtl/thread_pc_unit.sv
rtl/fetch_thread_arbiter.sv
rtl/itag_array.sv
rtl/itag_compare_stage.sv
rtl/ifetch_front.sv
verif/ifetch_front_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f flist.f --top-module ifetch_front_tb \
    -o sim_ifetch > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_ifetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0

/* verif/ifetch_front_tb.sv */
// Expects verif/fetch_input.txt relative to the run directory; 4 threads, fill ways picked at random
module ifetch_front_tb;
    import fetch_pkg::*;

    localparam addr_t RESET_PC = 32'h0000_1000;

    typedef struct packed {
        thread_idx_t thread;
        addr_t pc;
    } miss_rec_t;

    logic clk;
    logic reset;
    thread_bitmap_t fetch_en;
    logic rollback_en;
    thread_idx_t rollback_thread;
    addr_t rollback_pc;
    fill_t fill;
    thread_bitmap_t wake_bitmap;
    fetch_result_t result;
    logic miss_en;
    thread_idx_t miss_thread;
    addr_t miss_pc;

    // Reference state per thread
    addr_t exp_pc[4];
    int hits[4];
    int dis_cnt[4];
    logic [3:0] sleeping;
    logic fetch_started;
    miss_rec_t miss_q[$];

    // Shadow of the tag RAM built from the fills
    tag_t sh_tag[16][4];
    tag_t sh_prev[16][4];
    logic sh_valid[16][4];
    time sh_time[16][4];

    byte cmd_code[$];
    logic [31:0] cmd_a[$];
    logic [31:0] cmd_b[$];
    int wsum;
    int fill_count;
    int mismatch_errors;
    int other_errors;

    ifetch_front #(
        .NUM_THREADS(4),
        .RESET_PC(RESET_PC)
    ) i_ifetch_front (
        .clk,
        .reset,
        .fetch_en,
        .rollback_en,
        .rollback_thread,
        .rollback_pc,
        .fill,
        .wake_bitmap,
        .result,
        .miss_en,
        .miss_thread,
        .miss_pc
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic load_commands();
        int fd;
        int n;
        string line;
        byte code;
        logic [31:0] a;
        logic [31:0] b;

        fd = $fopen("verif/fetch_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the command file verif/fetch_input.txt");
            other_errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#")
                begin
                    a = '0;
                    b = '0;
                    n = $sscanf(line, "%c %h %h", code, a, b);
                    if (code == "W" || code == "C")
                        n = $sscanf(line, "%c %d %d", code, a, b);
                    if (code == "E" || code == "R" || code == "W" || code == "C")
                    begin
                        cmd_code.push_back(code);
                        cmd_a.push_back(a);
                        cmd_b.push_back(b);
                        if (code == "W")
                            wsum += int'(a);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    endtask

    task automatic check_result();
        thread_idx_t t;
        set_idx_t s;
        way_idx_t w;
        tag_t tag;
        logic line_ok;

        t = result.thread;
        s = result.pc[9:6];
        w = result.way;
        tag = result.pc[31:10];
        assert (result.pc == exp_pc[t])
        else
        begin
            mismatch_errors++;
            $display("Mismatch at %0t: thread %0d result pc %h, expected %h",
                $time, t, result.pc, exp_pc[t]);
        end
        assert (!sleeping[t])
        else
        begin
            other_errors++;
            $display("Thread %0d delivered a result at %0t while waiting for a fill", t, $time);
        end
        assert (dis_cnt[t] <= 2)
        else
        begin
            other_errors++;
            $display("Thread %0d delivered a result at %0t while disabled", t, $time);
        end
        // A fill to this way at the last edge may have replaced the line just read
        line_ok = (sh_valid[s][w] && sh_tag[s][w] == tag)
            || ($time - sh_time[s][w] == 64'd20 && sh_prev[s][w] == tag);
        assert (line_ok)
        else
        begin
            mismatch_errors++;
            $display("Mismatch at %0t: thread %0d hit pc %h on way %0d, which holds no such line",
                $time, t, result.pc, w);
        end
        exp_pc[t] = exp_pc[t] + 32'd4;
        hits[t]++;
    endtask

    task automatic check_miss();
        miss_rec_t rec;

        assert (miss_pc == exp_pc[miss_thread])
        else
        begin
            mismatch_errors++;
            $display("Mismatch at %0t: thread %0d miss pc %h, expected %h",
                $time, miss_thread, miss_pc, exp_pc[miss_thread]);
        end
        assert (!sleeping[miss_thread])
        else
        begin
            other_errors++;
            $display("Thread %0d missed at %0t while already waiting", miss_thread, $time);
        end
        sleeping[miss_thread] = 1'b1;
        rec.thread = miss_thread;
        rec.pc = miss_pc;
        miss_q.push_back(rec);
    endtask

    // Outputs are sampled half a cycle after the edge that produced them
    always @(negedge clk)
    begin
        if (!fetch_started)
        begin
            assert (!result.valid && !miss_en)
            else
            begin
                other_errors++;
                $display("Result or miss seen at %0t before any thread was enabled", $time);
            end
        end
        if (!reset)
        begin
            for (int t = 0; t < 4; t++)
            begin
                if (fetch_en[t])
                    dis_cnt[t] = 0;
                else if (dis_cnt[t] < 1000)
                    dis_cnt[t]++;
            end
            if (result.valid)
                check_result();
            if (miss_en)
                check_miss();
            // Results already in flight still carry the old PC, so reload last
            if (rollback_en)
            begin
                exp_pc[rollback_thread] = rollback_pc;
                sleeping[rollback_thread] = 1'b0;
            end
        end
    end

    // Memory side: serves misses in order, fills the line, then wakes the thread
    initial
    begin
        miss_rec_t rec;
        int delay;
        set_idx_t s;
        way_idx_t w;

        fill = '0;
        wake_bitmap = '0;
        forever
        begin
            @(posedge clk);
            if (miss_q.size() > 0)
            begin
                rec = miss_q.pop_front();
                delay = 1 + ($urandom % 8);
                repeat (delay - 1) @(posedge clk);
                w = way_idx_t'($urandom % 4);
                s = rec.pc[9:6];
                fill.en <= 1'b1;
                fill.way <= w;
                fill.set <= s;
                fill.tag <= rec.pc[31:10];
                fill.valid <= 1'b1;
                @(posedge clk);
                sh_prev[s][w] = sh_tag[s][w];
                sh_tag[s][w] = rec.pc[31:10];
                sh_valid[s][w] = 1'b1;
                sh_time[s][w] = $time;
                fill_count++;
                sleeping[rec.thread] = 1'b0;
                fill.en <= 1'b0;
                wake_bitmap <= thread_bitmap_t'(1) << rec.thread;
                @(posedge clk);
                wake_bitmap <= '0;
            end
        end
    end

    // Watchdog
    initial
    begin
        longint limit;

        forever
        begin
            @(posedge clk);
            limit = longint'(wsum + 2 * cmd_code.size() + 64 * (fill_count + 1)) * 64'd40;
            if ($time > limit)
            begin
                other_errors++;
                $display("Timeout: the run did not finish in time at %0t", $time);
                report_counts();
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial
    begin
        int seed;

        seed = $urandom(32'h5f3e_5278);
        reset = 1'b1;
        fetch_en = '0;
        rollback_en = 1'b0;
        rollback_thread = '0;
        rollback_pc = '0;
        sleeping = '0;
        fetch_started = 1'b0;
        for (int t = 0; t < 4; t++)
        begin
            exp_pc[t] = RESET_PC;
            hits[t] = 0;
            dis_cnt[t] = 0;
        end
        for (int s = 0; s < 16; s++)
        begin
            for (int w = 0; w < 4; w++)
            begin
                sh_tag[s][w] = '0;
                sh_prev[s][w] = '0;
                sh_valid[s][w] = 1'b0;
                sh_time[s][w] = 0;
            end
        end
        load_commands();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < cmd_code.size(); i++)
        begin
            case (cmd_code[i])
                "E":
                begin
                    @(posedge clk);
                    fetch_en <= thread_bitmap_t'(cmd_a[i]);
                    if (cmd_a[i] != 0)
                        fetch_started = 1'b1;
                end
                "R":
                begin
                    @(posedge clk);
                    rollback_en <= 1'b1;
                    rollback_thread <= thread_idx_t'(cmd_a[i]);
                    rollback_pc <= cmd_b[i];
                    @(posedge clk);
                    rollback_en <= 1'b0;
                end
                "W":
                    repeat (cmd_a[i]) @(posedge clk);
                default:
                begin
                    assert (hits[cmd_a[i][1:0]] >= int'(cmd_b[i]))
                    else
                    begin
                        other_errors++;
                        $display("Thread %0d reached only %0d hits, at least %0d expected",
                            cmd_a[i], hits[cmd_a[i][1:0]], cmd_b[i]);
                    end
                end
            endcase
        end

        repeat (16) @(posedge clk);
        report_counts();
        if (mismatch_errors == 0 && other_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* rtl/ifetch_front.sv */
// NUM_THREADS from 1 to 4; fetch_en and wake_bitmap bits above NUM_THREADS are ignored
module ifetch_front import fetch_pkg::*;
#(
    parameter int    NUM_THREADS = 4,
    parameter addr_t RESET_PC = '0
)
(
    input  logic           clk,
    input  logic           reset,
    input  thread_bitmap_t fetch_en,
    input  logic           rollback_en,
    input  thread_idx_t    rollback_thread,
    input  addr_t          rollback_pc,
    input  fill_t          fill,
    input  thread_bitmap_t wake_bitmap,
    output fetch_result_t  result,
    output logic           miss_en,
    output thread_idx_t    miss_thread,
    output addr_t          miss_pc
);

    thread_ctrl_t thread_ctrl[NUM_THREADS];
    thread_bitmap_t ready_bitmap;
    addr_t pc_array[NUM_THREADS];
    thread_idx_t sel_thread;
    logic sel_fire;
    lookup_t lookup;
    tag_stage_t stage;

    fetch_event_decoder #(
        .NUM_THREADS(NUM_THREADS)
    ) i_fetch_event_decoder (
        .clk,
        .reset,
        .rollback_en,
        .rollback_thread,
        .rollback_pc,
        .miss_en,
        .miss_thread,
        .wake_bitmap,
        .sel_thread,
        .sel_fire,
        .thread_ctrl
    );

    // Threads above NUM_THREADS never request
    for (genvar t = 0; t < MAX_THREADS; t++)
    begin : thread_gen
        if (t < NUM_THREADS)
        begin : pc_gen
            thread_pc_unit #(
                .RESET_PC(RESET_PC)
            ) i_thread_pc_unit (
                .clk,
                .reset,
                .ctrl(thread_ctrl[t]),
                .enable(fetch_en[t]),
                .ready(ready_bitmap[t]),
                .pc(pc_array[t])
            );
        end
        else
        begin : idle_gen
            assign ready_bitmap[t] = 1'b0;
        end
    end

    fetch_thread_arbiter #(
        .NUM_THREADS(NUM_THREADS)
    ) i_fetch_thread_arbiter (
        .clk,
        .reset,
        .ready_bitmap,
        .pc_array,
        .rollback_en,
        .rollback_thread,
        .miss_en,
        .miss_thread,
        .sel_thread,
        .sel_pc(),
        .sel_fire,
        .lookup
    );

    itag_array i_itag_array (
        .clk,
        .reset,
        .lookup,
        .fill,
        .rollback_en,
        .rollback_thread,
        .stage
    );

    itag_compare_stage i_itag_compare_stage (
        .clk,
        .reset,
        .stage,
        .miss_en,
        .miss_thread,
        .miss_pc,
        .result
    );

endmodule

/* rtl/itag_compare_stage.sv */
// Hit if any valid way matches; a line present in two ways reports the highest way
module itag_compare_stage import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  tag_stage_t    stage,
    output logic          miss_en,
    output thread_idx_t   miss_thread,
    output addr_t         miss_pc,
    output fetch_result_t result
);

    tag_t lookup_tag;
    logic [NUM_WAYS-1:0] hit_oh;
    logic hit;
    way_idx_t hit_way;
    logic result_valid;
    thread_idx_t result_thread;
    addr_t result_pc;
    way_idx_t result_way;

    assign lookup_tag = pc_tag(stage.pc);

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            hit_oh[w] = stage.way_valid[w] && stage.tags[w] == lookup_tag;
            if (hit_oh[w])
                hit_way = way_idx_t'(w);
        end
    end

    assign hit = |hit_oh;

    // Miss report goes out in the same cycle as the compare
    assign miss_en = stage.valid && !hit;
    assign miss_thread = stage.thread;
    assign miss_pc = stage.pc;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= stage.valid && hit;
    end

    always_ff @(posedge clk)
    begin
        result_thread <= stage.thread;
        result_pc <= stage.pc;
        result_way <= hit_way;
    end

    assign result.valid = result_valid;
    assign result.thread = result_thread;
    assign result.pc = result_pc;
    assign result.way = result_way;

endmodule

/* rtl/itag_array.sv */
// Tag RAM has one read and one write port per way; fills win over lookups to the same set
module itag_array import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  lookup_t     lookup,
    input  fill_t       fill,
    input  logic        rollback_en,
    input  thread_idx_t rollback_thread,
    output tag_stage_t  stage
);

    set_idx_t lookup_set;
    logic stage_valid;
    thread_idx_t stage_thread;
    addr_t stage_pc;
    tag_t way_tags[NUM_WAYS];
    logic way_valid[NUM_WAYS];

    assign lookup_set = pc_set(lookup.pc);

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : way_gen
        tag_t tag_mem[NUM_SETS];
        logic [NUM_SETS-1:0] line_valid;
        logic fill_way;
        logic fill_same_set;

        assign fill_way = fill.en && fill.way == way_idx_t'(w);
        assign fill_same_set = fill_way && fill.set == lookup_set;

        always_ff @(posedge clk)
        begin
            if (fill_way)
                tag_mem[fill.set] <= fill.tag;
        end

        // One valid bit per set, every line invalid after reset
        always_ff @(posedge clk, posedge reset)
        begin
            if (reset)
                line_valid <= '0;
            else if (fill_way)
                line_valid[fill.set] <= fill.valid;
        end

        // Read during write returns the new line
        always_ff @(posedge clk)
        begin
            if (lookup.valid)
            begin
                if (fill_same_set)
                begin
                    way_tags[w] <= fill.tag;
                    way_valid[w] <= fill.valid;
                end
                else
                begin
                    way_tags[w] <= tag_mem[lookup_set];
                    way_valid[w] <= line_valid[lookup_set];
                end
            end
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            stage_valid <= 1'b0;
        else
            stage_valid <= lookup.valid;
    end

    always_ff @(posedge clk)
    begin
        stage_thread <= lookup.thread;
        stage_pc <= lookup.pc;
    end

    // An entry whose thread is redirected this cycle is dropped
    always_comb
    begin
        stage.valid = stage_valid && !(rollback_en && rollback_thread == stage_thread);
        stage.thread = stage_thread;
        stage.pc = stage_pc;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            stage.tags[w] = way_tags[w];
            stage.way_valid[w] = way_valid[w];
        end
    end

endmodule

/* rtl/fetch_thread_arbiter.sv */
// Picks one ready thread per cycle in round-robin order; no back-pressure from the cache
module fetch_thread_arbiter import fetch_pkg::*;
#(
    parameter int NUM_THREADS = 4
)
(
    input  logic           clk,
    input  logic           reset,
    input  thread_bitmap_t ready_bitmap,
    input  addr_t          pc_array[NUM_THREADS],
    input  logic           rollback_en,
    input  thread_idx_t    rollback_thread,
    input  logic           miss_en,
    input  thread_idx_t    miss_thread,
    output thread_idx_t    sel_thread,
    output addr_t          sel_pc,
    output logic           sel_fire,
    output lookup_t        lookup
);

    thread_idx_t rr_ptr;
    logic squash;

    // Search starts at the pointer and wraps at NUM_THREADS
    always_comb
    begin
        int cand;

        sel_fire = 1'b0;
        sel_thread = '0;
        for (int i = 0; i < NUM_THREADS; i++)
        begin
            cand = int'(rr_ptr) + i;
            if (cand >= NUM_THREADS)
                cand = cand - NUM_THREADS;
            if (!sel_fire && ready_bitmap[cand])
            begin
                sel_fire = 1'b1;
                sel_thread = thread_idx_t'(cand);
            end
        end
    end

    // Next search begins just past the granted thread
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            rr_ptr <= '0;
        else if (sel_fire)
        begin
            if (sel_thread == thread_idx_t'(NUM_THREADS - 1))
                rr_ptr <= '0;
            else
                rr_ptr <= sel_thread + thread_idx_t'(1);
        end
    end

    assign sel_pc = pc_array[sel_thread];

    // Rollback and miss arrive late in the cycle, so a ready thread is still picked
    // and the request is dropped instead
    assign squash = (rollback_en && rollback_thread == sel_thread)
        || (miss_en && miss_thread == sel_thread);

    assign lookup.valid = sel_fire && !squash;
    assign lookup.thread = sel_thread;
    assign lookup.pc = sel_pc;

endmodule

/* rtl/thread_pc_unit.sv */
// One PC per thread; PCs step by 4 bytes, so fetch is one 32-bit instruction per selection
module thread_pc_unit import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = '0
)
(
    input  logic         clk,
    input  logic         reset,
    input  thread_ctrl_t ctrl,
    input  logic         enable,
    output logic         ready,
    output addr_t        pc
);

    logic waiting;

    // Rollback beats rewind, rewind beats advance
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            pc <= RESET_PC;
        else if (ctrl.rollback)
            pc <= ctrl.rollback_pc;
        else if (ctrl.rewind)
            pc <= pc - addr_t'(4);
        else if (ctrl.advance)
            pc <= pc + addr_t'(4);
    end

    // Set on a miss, released by the wake bitmap or a redirect
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            waiting <= 1'b0;
        else if (ctrl.rollback || ctrl.wake)
            waiting <= 1'b0;
        else if (ctrl.sleep)
            waiting <= 1'b1;
    end

    assign ready = enable && !waiting;

endmodule

/* rtl/fetch_event_decoder.sv */
// Rollback and miss thread indices are expected below NUM_THREADS; out-of-range indices are ignored
module fetch_event_decoder import fetch_pkg::*;
#(
    parameter int NUM_THREADS = 4
)
(
    input  logic           clk,
    input  logic           reset,
    input  logic           rollback_en,
    input  thread_idx_t    rollback_thread,
    input  addr_t          rollback_pc,
    input  logic           miss_en,
    input  thread_idx_t    miss_thread,
    input  thread_bitmap_t wake_bitmap,
    input  thread_idx_t    sel_thread,
    input  logic           sel_fire,
    output thread_ctrl_t   thread_ctrl[NUM_THREADS]
);

    thread_idx_t last_sel_thread;

    // The lookup resolving in the compare stage now was selected one cycle ago
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            last_sel_thread <= '0;
        else
            last_sel_thread <= sel_thread;
    end

    always_comb
    begin
        for (int t = 0; t < NUM_THREADS; t++)
        begin
            thread_ctrl[t].rollback = rollback_en && rollback_thread == thread_idx_t'(t);
            thread_ctrl[t].rollback_pc = rollback_pc;

            // Undo the advance taken when the missing fetch was issued
            thread_ctrl[t].rewind = miss_en && last_sel_thread == thread_idx_t'(t);
            thread_ctrl[t].advance = sel_fire && sel_thread == thread_idx_t'(t);

            // Thread sleeps until the fill for its line arrives
            thread_ctrl[t].sleep = miss_en && miss_thread == thread_idx_t'(t);
            thread_ctrl[t].wake = wake_bitmap[t];
        end
    end

endmodule

/* rtl/fetch_pkg.sv */
// Physical addresses only; 64-byte lines, 16 sets, 4 ways and at most 4 hardware threads
package fetch_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int OFFSET_BITS = 6;
    localparam int NUM_SETS = 16;
    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;
    localparam int NUM_WAYS = 4;
    localparam int MAX_THREADS = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;
    typedef logic [$clog2(MAX_THREADS)-1:0] thread_idx_t;
    typedef logic [MAX_THREADS-1:0] thread_bitmap_t;

    // Decoder to one PC unit
    typedef struct packed {
        logic rollback;
        addr_t rollback_pc;
        logic rewind;
        logic advance;
        logic sleep;
        logic wake;
    } thread_ctrl_t;

    // Arbiter to tag array
    typedef struct packed {
        logic valid;
        thread_idx_t thread;
        addr_t pc;
    } lookup_t;

    // Tag array to compare stage
    typedef struct packed {
        logic valid;
        thread_idx_t thread;
        addr_t pc;
        tag_t [NUM_WAYS-1:0] tags;
        logic [NUM_WAYS-1:0] way_valid;
    } tag_stage_t;

    // Line fill from the memory side
    typedef struct packed {
        logic en;
        way_idx_t way;
        set_idx_t set;
        tag_t tag;
        logic valid;
    } fill_t;

    typedef struct packed {
        logic valid;
        thread_idx_t thread;
        addr_t pc;
        way_idx_t way;
    } fetch_result_t;

    function automatic set_idx_t pc_set(addr_t pc);
        return pc[OFFSET_BITS +: SET_BITS];
    endfunction

    function automatic tag_t pc_tag(addr_t pc);
        return pc[ADDR_WIDTH-1 -: TAG_BITS];
    endfunction

endpackage
